/* src/irq_pkg.sv */
package irq_pkg;

  // number of interrupt lines
  localparam int INT_VECT_LEN = 8;

  // width of a line index
  localparam int OFFSET_LEN = $clog2(INT_VECT_LEN);

  // timer takes the highest line, so every external source beats it
  localparam int TIMER_IRQ_BIT = 7;

  // service sequence as seen by the core
  typedef enum logic [1:0] {
    // nothing captured
    IRQ_IDLE    = 2'd0,
    // line captured, waiting for advance
    IRQ_TAKEN   = 2'd1,
    // offset valid, waiting for clear
    IRQ_SERVICE = 2'd2
  } irq_state_e;

  // mask write request
  typedef struct packed {
    logic                    write;
    logic [INT_VECT_LEN-1:0] mask;
  } irq_mask_wr_t;

  // status word returned to the core
  typedef struct packed {
    irq_state_e              state;
    // one-hot, zero when idle
    logic [INT_VECT_LEN-1:0] handling;
    logic [INT_VECT_LEN-1:0] mask;
  } irq_status_t;

endpackage

/* src/irq_timer.sv */
`timescale 1ns/10ps

module irq_timer #(
  parameter int TIMER_PERIOD = 64
) (
  input  logic clk_i,
  input  logic arst_n_i,
  output logic timer_pulse_o
);

  // a period of one still needs a one-bit counter
  localparam int CNT_W = (TIMER_PERIOD > 1) ? $clog2(TIMER_PERIOD) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TIMER_PERIOD - 1);

  logic [CNT_W-1:0] count_q;
  logic             wrap;

  // last count of the period
  assign wrap = (count_q == CNT_LAST);

  // free-running counter, 0 .. TIMER_PERIOD-1
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (wrap) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  // one cycle high per period
  assign timer_pulse_o = wrap;

endmodule

/* src/irq_pending.sv */
`timescale 1ns/10ps

module irq_pending (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic [irq_pkg::INT_VECT_LEN-1:0] lines_i,
  input  irq_pkg::irq_mask_wr_t           mask_wr_i,
  input  logic                            clear_i,
  input  logic [irq_pkg::INT_VECT_LEN-1:0] handling_i,
  output logic [irq_pkg::INT_VECT_LEN-1:0] mask_o,
  output logic [irq_pkg::INT_VECT_LEN-1:0] lowest_o
);

  import irq_pkg::*;

  logic [INT_VECT_LEN-1:0] mask_q;
  logic [INT_VECT_LEN-1:0] pending_q;
  logic [INT_VECT_LEN-1:0] masked;
  logic [INT_VECT_LEN-1:0] pending_d;

  // only enabled lines reach the pending register
  assign masked = lines_i & mask_q;

  // mask register, new value visible after the write edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mask_q <= '0;
    end else if (mask_wr_i.write) begin
      mask_q <= mask_wr_i.mask;
    end
  end

  // sticky pending bits
  // clear toggles out the serviced bit; handling is zero when idle
  always_comb begin
    if (clear_i) begin
      pending_d = (pending_q ^ handling_i) | masked;
    end else begin
      pending_d = pending_q | masked;
    end
  end

  // masking a line later does not drop a bit already pending
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  // lowest index wins
  always_comb begin
    logic found;
    found    = 1'b0;
    lowest_o = '0;
    for (int i = 0; i < INT_VECT_LEN; i++) begin
      if (pending_q[i] && !found) begin
        lowest_o[i] = 1'b1;
        found       = 1'b1;
      end
    end
  end

  assign mask_o = mask_q;

endmodule

/* src/irq_fsm.sv */
`timescale 1ns/10ps

module irq_fsm #(
  parameter int XLEN = 32
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic [irq_pkg::INT_VECT_LEN-1:0] lowest_i,
  input  logic                            advance_i,
  input  logic                            clear_i,
  output irq_pkg::irq_state_e             state_o,
  output logic [irq_pkg::INT_VECT_LEN-1:0] handling_o,
  output logic [XLEN-1:0]                 vector_offset_o
);

  import irq_pkg::*;

  irq_state_e              state_q;
  irq_state_e              state_d;
  logic [INT_VECT_LEN-1:0] handling_q;
  logic [OFFSET_LEN-1:0]   index;
  logic [XLEN-1:0]         offset_full;
  logic [XLEN-1:0]         offset_q;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IRQ_IDLE: begin
        if (lowest_i != '0) begin
          state_d = IRQ_TAKEN;
        end
      end
      IRQ_TAKEN: begin
        if (advance_i) begin
          state_d = IRQ_SERVICE;
        end
      end
      IRQ_SERVICE: begin
        if (clear_i) begin
          state_d = IRQ_IDLE;
        end
      end
      default: begin
        state_d = IRQ_IDLE;
      end
    endcase
  end

  // one-hot handling to line index
  always_comb begin
    index = '0;
    for (int i = 0; i < INT_VECT_LEN; i++) begin
      if (handling_q[i]) begin
        index = OFFSET_LEN'(i);
      end
    end
  end

  // word-aligned byte offset into the vector table
  assign offset_full = {{(XLEN - OFFSET_LEN - 2){1'b0}}, index, 2'b00};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= IRQ_IDLE;
      handling_q <= '0;
      offset_q   <= '0;
    end else begin
      state_q <= state_d;
      // capture the winning line
      if (state_q == IRQ_IDLE && lowest_i != '0) begin
        handling_q <= lowest_i;
      end
      // offset valid from IRQ_SERVICE on
      if (state_q == IRQ_TAKEN && advance_i) begin
        offset_q <= offset_full;
      end
      // release the line
      if (state_q == IRQ_SERVICE && clear_i) begin
        handling_q <= '0;
      end
    end
  end

  assign state_o         = state_q;
  assign handling_o      = handling_q;
  assign vector_offset_o = offset_q;

endmodule

/* src/irq_ctrl_top.sv */
`timescale 1ns/10ps

module irq_ctrl_top #(
  parameter int XLEN         = 32,
  parameter int TIMER_PERIOD = 64
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic [irq_pkg::INT_VECT_LEN-1:0] irq_lines_i,
  input  irq_pkg::irq_mask_wr_t           mask_wr_i,
  input  logic                            advance_i,
  input  logic                            clear_i,
  output irq_pkg::irq_status_t            status_o,
  output logic [XLEN-1:0]                 vector_offset_o
);

  import irq_pkg::*;

  logic                    timer_pulse;
  logic [INT_VECT_LEN-1:0] lines_merged;
  logic [INT_VECT_LEN-1:0] lowest;
  logic [INT_VECT_LEN-1:0] mask_q;
  logic [INT_VECT_LEN-1:0] handling;
  irq_state_e              state;

  irq_timer #(
    .TIMER_PERIOD (TIMER_PERIOD)
  ) irq_timer_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .timer_pulse_o (timer_pulse)
  );

  // timer shares the external line at TIMER_IRQ_BIT
  assign lines_merged = irq_lines_i | (INT_VECT_LEN'(timer_pulse) << TIMER_IRQ_BIT);

  irq_pending irq_pending_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .lines_i    (lines_merged),
    .mask_wr_i  (mask_wr_i),
    .clear_i    (clear_i),
    .handling_i (handling),
    .mask_o     (mask_q),
    .lowest_o   (lowest)
  );

  irq_fsm #(
    .XLEN (XLEN)
  ) irq_fsm_inst (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .lowest_i        (lowest),
    .advance_i       (advance_i),
    .clear_i         (clear_i),
    .state_o         (state),
    .handling_o      (handling),
    .vector_offset_o (vector_offset_o)
  );

  assign status_o = '{state: state, handling: handling, mask: mask_q};

endmodule

/* tb/irq_ctrl_tb.sv */
`timescale 1ns/10ps

module irq_ctrl_tb;

  import irq_pkg::*;

  localparam int XLEN         = 32;
  // short period so a timer pulse always lands inside one wait window
  localparam int TIMER_PERIOD = 16;
  localparam int WAIT_LIMIT   = TIMER_PERIOD + 4;
  localparam int QUIET_LIMIT  = 4;
  localparam logic [7:0] NO_IRQ = 8'hff;

  logic                    clk_i;
  logic                    arst_n_i;
  logic [INT_VECT_LEN-1:0] irq_lines_i;
  irq_mask_wr_t            mask_wr_i;
  logic                    advance_i;
  logic                    clear_i;
  irq_status_t             status_o;
  logic [XLEN-1:0]         vector_offset_o;

  int errors;
  int checks;

  irq_ctrl_top #(
    .XLEN         (XLEN),
    .TIMER_PERIOD (TIMER_PERIOD)
  ) irq_ctrl_top_inst (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .irq_lines_i     (irq_lines_i),
    .mask_wr_i       (mask_wr_i),
    .advance_i       (advance_i),
    .clear_i         (clear_i),
    .status_o        (status_o),
    .vector_offset_o (vector_offset_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic check_status(input irq_status_t got, input irq_status_t exp,
                              input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_offset(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  // samples on the falling edge, away from register updates
  task automatic wait_for_state(input irq_state_e state, input int limit, output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < limit) begin
      @(negedge clk_i);
      cycles++;
      if (status_o.state == state) begin
        seen = 1'b1;
      end
    end
  endtask

  task automatic write_mask(input logic [INT_VECT_LEN-1:0] mask);
    irq_status_t exp;
    exp = '{state: IRQ_IDLE, handling: '0, mask: mask};
    @(posedge clk_i);
    mask_wr_i <= '{write: 1'b1, mask: mask};
    @(posedge clk_i);
    mask_wr_i.write <= 1'b0;
    @(negedge clk_i);
    check_status(status_o, exp, "status_o");
  endtask

  task automatic pulse_lines(input logic [INT_VECT_LEN-1:0] lines);
    @(posedge clk_i);
    irq_lines_i <= lines;
    @(posedge clk_i);
    irq_lines_i <= '0;
  endtask

  task automatic pulse_advance();
    @(posedge clk_i);
    advance_i <= 1'b1;
    @(posedge clk_i);
    advance_i <= 1'b0;
  endtask

  task automatic pulse_clear();
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
  endtask

  // take, advance and clear one line, checking each step
  task automatic service_line(input logic [INT_VECT_LEN-1:0] mask, input int k);
    irq_status_t exp;
    bit          seen;
    exp.mask     = mask;
    exp.handling = INT_VECT_LEN'(1) << k;
    exp.state    = IRQ_TAKEN;
    wait_for_state(IRQ_TAKEN, WAIT_LIMIT, seen);
    if (!seen) begin
      errors++;
      $display("line %0d was never taken within %0d cycles", k, WAIT_LIMIT);
    end else begin
      check_status(status_o, exp, "status_o");
      pulse_advance();
      wait_for_state(IRQ_SERVICE, WAIT_LIMIT, seen);
      if (!seen) begin
        errors++;
        $display("line %0d did not reach service after advance", k);
      end else begin
        exp.state = IRQ_SERVICE;
        check_status(status_o, exp, "status_o");
        check_offset(vector_offset_o, XLEN'(4 * k), "vector_offset_o");
        pulse_clear();
        wait_for_state(IRQ_IDLE, WAIT_LIMIT, seen);
        if (!seen) begin
          errors++;
          $display("line %0d did not return to idle after clear", k);
        end else begin
          exp.state    = IRQ_IDLE;
          exp.handling = '0;
          check_status(status_o, exp, "status_o");
        end
      end
    end
  endtask

  task automatic run_pattern(input logic [7:0] mask, input logic [7:0] lines,
                             input logic [7:0] expected_idx);
    bit seen;
    write_mask(mask);
    pulse_lines(lines);
    if (expected_idx == NO_IRQ) begin
      wait_for_state(IRQ_TAKEN, WAIT_LIMIT, seen);
      if (seen) begin
        errors++;
        $display("interrupt taken although mask %h blocks lines %h", mask, lines);
      end
    end else begin
      service_line(mask, int'(expected_idx));
      // lowest index first, so the rest follow in ascending order
      for (int k = int'(expected_idx) + 1; k < INT_VECT_LEN; k++) begin
        if (lines[k] && mask[k]) begin
          service_line(mask, k);
        end
      end
      // every line is serviced once only
      if (lines != '0) begin
        wait_for_state(IRQ_TAKEN, QUIET_LIMIT, seen);
        if (seen) begin
          errors++;
          $display("extra interrupt after lines %h were all serviced", lines);
        end
      end
    end
  endtask

  initial begin
    int               fd;
    int               count;
    logic [8*128-1:0] line_buf;
    logic [7:0]       mask;
    logic [7:0]       lines;
    logic [7:0]       expected_idx;
    irq_status_t      exp;
    errors = 0;
    checks = 0;
    arst_n_i    <= 1'b0;
    irq_lines_i <= '0;
    mask_wr_i   <= '0;
    advance_i   <= 1'b0;
    clear_i     <= 1'b0;
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    exp = '{state: IRQ_IDLE, handling: '0, mask: '0};
    check_status(status_o, exp, "status_o");
    check_offset(vector_offset_o, '0, "vector_offset_o");
    fd = $fopen("tb/irq_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the pattern file tb/irq_patterns.txt");
    end else begin
      // comment and blank lines do not parse as three hex fields
      while ($fgets(line_buf, fd) != 0) begin
        count = $sscanf(line_buf, "%h %h %h", mask, lines, expected_idx);
        if (count == 3) begin
          run_pattern(mask, lines, expected_idx);
        end
      end
      $fclose(fd);
    end
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* tb/irq_patterns.txt */
# columns: mask, lines pulsed for one cycle, first line index expected (all hex)
# ff as index means no interrupt; bit 7 stays masked until the timer case at the end
01 01 00
02 02 01
04 04 02
08 08 03
10 10 04
20 20 05
40 40 06
7f 00 ff
0f f0 ff
00 3f ff
55 aa ff
7f 80 ff
7f 7f 00
7f 6c 02
3c 3c 02
70 50 04
0e 0a 01
2a ff 01
7f 41 00
60 60 05
03 03 00
18 1c 03
80 00 07

/* all.f */
src/irq_pkg.sv
src/irq_timer.sv
src/irq_pending.sv
src/irq_fsm.sv
src/irq_ctrl_top.sv
tb/irq_ctrl_tb.sv
